// File: sim.f
+incdir+.
fpga_pkg.sv
cpu_bus_if.sv
cpu_bus_decoder.sv
ctl_regs.sv
mod_mem.sv
duty_phase_mem.sv
mod_sampler.sv
drive_scanner.sv
fpga_top.sv
fpga_properties.sv
tb_fpga_top.sv

// File: Makefile
# Verilator build and run of tb_fpga_top
VERILATOR ?= verilator
TOP       ?= tb_fpga_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_fpga_top.sv
// Directed test of the CPU bus write path, modulation sampler and drive scan
// Expected values come from model arrays kept here, write timing as in fpga_top
// Unwritten modulation words read as X while the index sweeps through them
`timescale 1ns/1ps
`default_nettype none

`include "fpga_consts.svh"

module tb_fpga_top;

  localparam int          TIMEOUT_CYCLES = 45000;
  localparam logic [15:0] FAN_WORD  = 16'(1) << `CTL_FLAG_FORCE_FAN_BIT;
  localparam logic [15:0] SYNC_WORD = 16'(1) << `CTL_FLAG_SYNC_BIT;

  logic        CPU_CKIO;
  logic        arst_n;
  logic        cs1_n;
  logic        we0_n;
  logic [16:0] addr;
  logic [15:0] data;
  logic [7:0]  mod_sample;
  logic [7:0]  duty_out;
  logic [7:0]  phase_out;
  logic [7:0]  drive_idx;
  logic        drive_valid;
  logic        force_fan;

  logic [7:0] dp_duty  [`NUM_TRANS];
  logic [7:0] dp_phase [`NUM_TRANS];
  logic [7:0] samples  [16];
  logic [7:0] pg1_even;
  logic [7:0] pg1_odd;
  int         err_cnt;
  int         err_base;
  int         test_cnt;
  int         test_fail_cnt;
  int         cycles;

  fpga_top dut_i (.*);

  initial begin
    CPU_CKIO = 1'b0;
    forever #2 CPU_CKIO = ~CPU_CKIO;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CPU_CKIO);
      cycles++;
    end
    $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////
  // Bus access and checks
  task automatic bus_write(input logic [1:0] sel, input logic [13:0] waddr,
                           input logic [15:0] wdata);
    @(posedge CPU_CKIO);
    cs1_n <= 1'b0;
    addr  <= {sel, waddr, 1'b0};
    data  <= wdata;
    @(posedge CPU_CKIO);
    we0_n <= 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    we0_n <= 1'b1;
    @(posedge CPU_CKIO);  // Bank has taken the write on this edge
    cs1_n <= 1'b1;
  endtask

  task automatic ctl_write(input logic [13:0] waddr, input logic [15:0] wdata);
    bus_write(`BRAM_SELECT_CONTROLLER, waddr, wdata);
  endtask

  task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  function automatic logic [7:0] scale_duty(input logic [7:0] duty, input logic [7:0] m);
    logic [15:0] p;
    p = 16'(duty) * 16'(m);
    return p[15:8];
  endfunction

  // Sample k expected for div_len cycles in a row
  task automatic check_mod_seq(input int div_len, input int n_cycles);
    for (int n = 0; n < n_cycles; n++) begin
      @(negedge CPU_CKIO);
      check_eq("mod_sample", mod_sample, samples[4'((n / div_len) % 16)]);
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt != err_base) begin
      test_fail_cnt++;
    end
    $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  ////////////////////
  // Tests
  initial begin
    void'($urandom(32'hd6ee5cd5));
    arst_n        = 1'b0;
    cs1_n         = 1'b1;
    we0_n         = 1'b1;
    addr          = '0;
    data          = '0;
    err_cnt       = 0;
    err_base      = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;

    repeat (10) begin
      @(negedge CPU_CKIO);
      check_eq("drive_valid", 8'(drive_valid), 8'd0);
      check_eq("force_fan", 8'(force_fan), 8'd0);
    end
    @(posedge CPU_CKIO);
    arst_n <= 1'b1;
    repeat (5) begin
      @(negedge CPU_CKIO);
      check_eq("force_fan", 8'(force_fan), 8'd0);
    end
    end_test("reset");

    // Constant full-scale modulation at index 0
    bus_write(`BRAM_SELECT_MOD, 14'd0, 16'hffff);
    ctl_write(`ADDR_MOD_CYCLE, 16'd0);
    ctl_write(`ADDR_MOD_FREQ_DIV_0, 16'hffff);
    ctl_write(`ADDR_MOD_FREQ_DIV_1, 16'hffff);
    for (int i = 0; i < `NUM_TRANS; i++) begin
      dp_duty[8'(i)]  = 8'($urandom());
      dp_phase[8'(i)] = 8'($urandom());
      bus_write(`BRAM_SELECT_NORMAL, 14'(i), {dp_duty[8'(i)], dp_phase[8'(i)]});
    end
    repeat (4) @(posedge CPU_CKIO);
    for (int n = 0; n < 2 * `NUM_TRANS; n++) begin
      @(negedge CPU_CKIO);
      check_eq("drive_valid", 8'(drive_valid), 8'd1);
      check_eq("phase_out", phase_out, dp_phase[drive_idx]);
      check_eq("duty_out", duty_out, scale_duty(dp_duty[drive_idx], 8'd255));
    end
    end_test("normal bank");

    for (int w = 0; w < 8; w++) begin
      samples[4'(2 * w)]     = 8'($urandom());
      samples[4'(2 * w + 1)] = 8'($urandom());
      bus_write(`BRAM_SELECT_MOD, 14'(w), {samples[4'(2 * w + 1)], samples[4'(2 * w)]});
    end
    ctl_write(`ADDR_MOD_CYCLE, 16'd15);
    ctl_write(`ADDR_MOD_FREQ_DIV_0, 16'd3);
    ctl_write(`ADDR_MOD_FREQ_DIV_1, 16'd0);
    ctl_write(`ADDR_CTL_FLAG, SYNC_WORD);
    repeat (2) @(posedge CPU_CKIO);  // Index restart, then registered read
    check_mod_seq(4, 4 * 20);
    end_test("mod order");

    pg1_even = 8'($urandom());
    pg1_odd  = 8'($urandom());
    ctl_write(`ADDR_MOD_MEM_PAGE, 16'd1);
    bus_write(`BRAM_SELECT_MOD, 14'd0, {pg1_odd, pg1_even});
    ctl_write(`ADDR_MOD_CYCLE, 16'd32769);
    ctl_write(`ADDR_MOD_FREQ_DIV_0, 16'd0);
    ctl_write(`ADDR_CTL_FLAG, SYNC_WORD);
    repeat (32770) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    check_eq("mod_sample", mod_sample, pg1_even);
    @(negedge CPU_CKIO);
    check_eq("mod_sample", mod_sample, pg1_odd);
    @(negedge CPU_CKIO);
    check_eq("mod_sample", mod_sample, samples[0]);  // Wrapped to page 0
    end_test("page switch");

    ctl_write(`ADDR_CTL_FLAG, FAN_WORD);
    @(negedge CPU_CKIO);
    check_eq("force_fan", 8'(force_fan), 8'd1);
    ctl_write(`ADDR_MOD_CYCLE, 16'd15);
    ctl_write(`ADDR_MOD_FREQ_DIV_0, 16'd3);
    repeat (20 + ($urandom() % 20)) @(posedge CPU_CKIO);
    ctl_write(`ADDR_CTL_FLAG, FAN_WORD | SYNC_WORD);
    repeat (2) @(posedge CPU_CKIO);
    check_mod_seq(4, 8);
    check_eq("force_fan", 8'(force_fan), 8'd1);
    ctl_write(`ADDR_CTL_FLAG, 16'd0);
    @(negedge CPU_CKIO);
    check_eq("force_fan", 8'(force_fan), 8'd0);
    end_test("controls");

    $display("Done: %0d tests, %0d failed, %0d check errors, %0d property failures",
             test_cnt, test_fail_cnt, err_cnt, dut_i.props_i.fail_cnt);
    if (err_cnt == 0 && dut_i.props_i.fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fpga_properties.sv
// Concurrent checks on the decoded write strobe and the drive scan outputs
// Bound into fpga_top, wr is taken from the internal bus interface
`timescale 1ns/1ps
`default_nettype none

`include "fpga_consts.svh"

module fpga_properties (
  input wire logic       CPU_CKIO,
  input wire logic       arst_n,
  input wire logic       wr,
  input wire logic [7:0] drive_idx,
  input wire logic       drive_valid,
  input wire logic       force_fan
);

  localparam logic [7:0] LAST_IDX = 8'(`NUM_TRANS - 1);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end of the run

  wr_single: assert property (@(posedge CPU_CKIO) disable iff (!arst_n) wr |=> !wr)
    else begin
      $error("wr held high for more than one cycle");
      fail_cnt++;
    end

  ////////////////////
  // Drive scan
  idx_range: assert property (@(posedge CPU_CKIO) disable iff (!arst_n)
                              drive_idx < 8'(`NUM_TRANS))
    else begin
      $error("drive_idx beyond the last transducer");
      fail_cnt++;
    end

  idx_step: assert property (@(posedge CPU_CKIO) disable iff (!arst_n)
                             drive_valid |=> drive_idx ==
                             (($past(drive_idx) == LAST_IDX) ? 8'd0 : $past(drive_idx) + 8'd1))
    else begin
      $error("drive_idx did not step by one");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge CPU_CKIO)
                                !arst_n |-> !wr && !drive_valid && !force_fan)
    else begin
      $error("control output active during reset");
      fail_cnt++;
    end

endmodule

bind fpga_top fpga_properties props_i (
  .CPU_CKIO    (CPU_CKIO),
  .arst_n      (arst_n),
  .wr          (bus.wr),
  .drive_idx   (drive_idx),
  .drive_valid (drive_valid),
  .force_fan   (force_fan)
);

`default_nettype wire

// File: fpga_top.sv
// Write-only CPU bus front end with modulation and drive scan
// Single clock domain on CPU_CKIO, no bus read path, no STM bank
// mod_sample is exported so the modulation sequence can be observed
`timescale 1ns/1ps
`default_nettype none

module fpga_top (
  input  wire logic        CPU_CKIO,
  input  wire logic        arst_n,
  input  wire logic        cs1_n,
  input  wire logic        we0_n,
  input  wire logic [16:0] addr,
  input  wire logic [15:0] data,
  output logic [7:0]       mod_sample,
  output logic [7:0]       duty_out,
  output logic [7:0]       phase_out,
  output logic [7:0]       drive_idx,
  output logic             drive_valid,
  output logic             force_fan
);

  logic [15:0]           mod_cycle;
  logic [31:0]           mod_freq_div;
  logic                  mod_page;
  logic                  sync_pulse;
  logic [15:0]           sample_idx;
  logic [7:0]            scan_rd_idx;
  fpga_pkg::duty_phase_t scan_rd_word;

  cpu_bus_if bus ();

  ////////////////////
  // Bus input and register banks
  cpu_bus_decoder u_decoder (
    .CPU_CKIO (CPU_CKIO),
    .arst_n   (arst_n),
    .cs1_n    (cs1_n),
    .we0_n    (we0_n),
    .addr     (addr),
    .data     (data),
    .bus      (bus.master)
  );

  ctl_regs u_ctl_regs (
    .CPU_CKIO     (CPU_CKIO),
    .arst_n       (arst_n),
    .bus          (bus.slave),
    .mod_cycle    (mod_cycle),
    .mod_freq_div (mod_freq_div),
    .mod_page     (mod_page),
    .sync_pulse   (sync_pulse),
    .force_fan    (force_fan)
  );

  mod_mem u_mod_mem (
    .CPU_CKIO  (CPU_CKIO),
    .bus       (bus.slave),
    .page      (mod_page),
    .rd_idx    (sample_idx),
    .rd_sample (mod_sample)
  );

  duty_phase_mem u_dp_mem (
    .CPU_CKIO (CPU_CKIO),
    .bus      (bus.slave),
    .rd_idx   (scan_rd_idx),
    .rd_word  (scan_rd_word)
  );

  ////////////////////
  // Modulation and drive
  mod_sampler u_mod_sampler (
    .CPU_CKIO     (CPU_CKIO),
    .arst_n       (arst_n),
    .mod_cycle    (mod_cycle),
    .mod_freq_div (mod_freq_div),
    .sync_pulse   (sync_pulse),
    .sample_idx   (sample_idx)
  );

  drive_scanner u_scanner (
    .CPU_CKIO    (CPU_CKIO),
    .arst_n      (arst_n),
    .rd_idx      (scan_rd_idx),
    .rd_word     (scan_rd_word),
    .mod_sample  (mod_sample),
    .drive_idx   (drive_idx),
    .duty_out    (duty_out),
    .phase_out   (phase_out),
    .drive_valid (drive_valid)
  );

endmodule

`default_nettype wire

// File: drive_scanner.sv
// Scans all transducers continuously, one per cycle
// Two cycles from rd_idx to drive outputs, duty scaled by mod_sample / 256
// mod_sample is taken as it stands when the word reaches stage 2
`timescale 1ns/1ps
`default_nettype none

`include "fpga_consts.svh"

module drive_scanner (
  input  wire logic                  CPU_CKIO,
  input  wire logic                  arst_n,
  output logic [7:0]                 rd_idx,
  input  wire fpga_pkg::duty_phase_t rd_word,
  input  wire logic [7:0]            mod_sample,
  output logic [7:0]                 drive_idx,
  output logic [7:0]                 duty_out,
  output logic [7:0]                 phase_out,
  output logic                       drive_valid
);

  localparam logic [7:0] LAST_IDX = 8'(`NUM_TRANS - 1);

  logic [7:0]  scan_idx;
  logic [7:0]  idx_s1;
  logic        valid_s1;
  logic [15:0] prod;

  assign rd_idx = scan_idx;
  assign prod   = rd_word.duty * mod_sample;

  ////////////////////
  // Index counter and stage 1 (memory read in flight)
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      scan_idx <= '0;
      idx_s1   <= '0;
      valid_s1 <= 1'b0;
    end else begin
      scan_idx <= (scan_idx == LAST_IDX) ? 8'd0 : scan_idx + 8'd1;
      idx_s1   <= scan_idx;
      valid_s1 <= 1'b1;
    end
  end

  ////////////////////
  // Stage 2, scale and register outputs
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      drive_idx   <= '0;
      duty_out    <= '0;
      phase_out   <= '0;
      drive_valid <= 1'b0;
    end else begin
      drive_idx   <= idx_s1;
      duty_out    <= prod[15:8];  // duty * mod >> 8
      phase_out   <= rd_word.phase;
      drive_valid <= valid_s1;
    end
  end

endmodule

`default_nettype wire

// File: mod_sampler.sv
// Modulation index generator
// Index steps every mod_freq_div+1 cycles and wraps after mod_cycle
// sync_pulse restarts both the index and the divider
`timescale 1ns/1ps
`default_nettype none

module mod_sampler (
  input  wire logic        CPU_CKIO,
  input  wire logic        arst_n,
  input  wire logic [15:0] mod_cycle,
  input  wire logic [31:0] mod_freq_div,
  input  wire logic        sync_pulse,
  output logic [15:0]      sample_idx
);

  logic [31:0] div_cnt;

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt    <= '0;
      sample_idx <= '0;
    end else if (sync_pulse) begin
      div_cnt    <= '0;
      sample_idx <= '0;
    end else if (div_cnt == mod_freq_div) begin
      div_cnt <= '0;
      // >= also catches a cycle length lowered below the current index
      if (sample_idx >= mod_cycle) begin
        sample_idx <= '0;
      end else begin
        sample_idx <= sample_idx + 16'd1;
      end
    end else begin
      div_cnt <= div_cnt + 32'd1;
    end
  end

endmodule

`default_nettype wire

// File: duty_phase_mem.sv
// Duty/phase table, one word per transducer
// Writes at or beyond NUM_TRANS are dropped, read is registered
`timescale 1ns/1ps
`default_nettype none

`include "fpga_consts.svh"

module duty_phase_mem (
  input  wire logic          CPU_CKIO,
  cpu_bus_if.slave           bus,
  input  wire logic [7:0]    rd_idx,
  output fpga_pkg::duty_phase_t rd_word
);

  fpga_pkg::duty_phase_t mem [0:`NUM_TRANS-1];
  logic                  wr_en;

  assign wr_en = bus.wr && (bus.sel == `BRAM_SELECT_NORMAL)
                 && (bus.waddr < 14'(`NUM_TRANS));

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[bus.waddr[7:0]] <= bus.wdata.dp;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_word <= mem[rd_idx];  // rd_idx always below NUM_TRANS
  end

endmodule

`default_nettype wire

// File: mod_mem.sv
// Modulation sample memory, two pages of 16-bit words, two samples each
// Write page comes from the page register, read page from rd_idx[15]
// Read data appears one cycle after rd_idx
`timescale 1ns/1ps
`default_nettype none

`include "fpga_consts.svh"

module mod_mem (
  input  wire logic        CPU_CKIO,
  cpu_bus_if.slave         bus,
  input  wire logic        page,
  input  wire logic [15:0] rd_idx,
  output logic [7:0]       rd_sample
);

  localparam int DEPTH = 2 * `MOD_PAGE_WORDS;

  fpga_pkg::mod_pair_t mem [0:DEPTH-1];
  fpga_pkg::mod_pair_t rd_pair;
  logic                odd_q;

  ////////////////////
  // Write port
  always_ff @(posedge CPU_CKIO) begin
    if (bus.wr && (bus.sel == `BRAM_SELECT_MOD)) begin
      mem[{page, bus.waddr}] <= bus.wdata.pair;
    end
  end

  // Read port, word = idx >> 1 so idx[15] is the page
  always_ff @(posedge CPU_CKIO) begin
    rd_pair <= mem[rd_idx[15:1]];
    odd_q   <= rd_idx[0];
  end

  assign rd_sample = odd_q ? rd_pair.odd : rd_pair.even;

endmodule

`default_nettype wire

// File: ctl_regs.sv
// Controller register bank, write only
// Sync bit is not stored and only produces sync_pulse
// Unknown controller addresses are ignored
`timescale 1ns/1ps
`default_nettype none

`include "fpga_consts.svh"

module ctl_regs (
  input  wire logic   CPU_CKIO,
  input  wire logic   arst_n,
  cpu_bus_if.slave    bus,
  output logic [15:0] mod_cycle,
  output logic [31:0] mod_freq_div,
  output logic        mod_page,
  output logic        sync_pulse,
  output logic        force_fan
);

  logic ctl_wr;

  assign ctl_wr = bus.wr && (bus.sel == `BRAM_SELECT_CONTROLLER);

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      mod_cycle    <= '0;
      mod_freq_div <= '0;
      mod_page     <= 1'b0;
      sync_pulse   <= 1'b0;
      force_fan    <= 1'b0;
    end else begin
      sync_pulse <= 1'b0;  // One cycle only
      if (ctl_wr) begin
        case (bus.waddr)
          `ADDR_CTL_FLAG: begin
            force_fan  <= bus.wdata[`CTL_FLAG_FORCE_FAN_BIT];
            sync_pulse <= bus.wdata[`CTL_FLAG_SYNC_BIT];
          end
          `ADDR_MOD_MEM_PAGE: begin
            mod_page <= bus.wdata[0];
          end
          `ADDR_MOD_CYCLE: begin
            mod_cycle <= bus.wdata;
          end
          ////////////////////
          // Division value arrives as two halves
          `ADDR_MOD_FREQ_DIV_0: begin
            mod_freq_div[15:0] <= bus.wdata;
          end
          `ADDR_MOD_FREQ_DIV_1: begin
            mod_freq_div[31:16] <= bus.wdata;
          end
          default: begin
            // Silencer, delay and sync time addresses land here
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: cpu_bus_decoder.sv
// Turns the raw CPU strobes into a one-cycle write on cpu_bus_if
// Assumes addr and data are stable while cs1_n and we0_n are low
// addr[0] is not decoded
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_decoder (
  input  wire logic        CPU_CKIO,
  input  wire logic        arst_n,
  input  wire logic        cs1_n,
  input  wire logic        we0_n,
  input  wire logic [16:0] addr,
  input  wire logic [15:0] data,
  cpu_bus_if.master        bus
);

  logic cs_q;
  logic we_q;
  logic act_q;
  logic act;
  logic start;

  assign act   = ~cs_q & ~we_q;  // Both strobes sampled low
  assign start = act & ~act_q;

  ////////////////////
  // Strobe sampling and edge detect
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      cs_q   <= 1'b1;
      we_q   <= 1'b1;
      act_q  <= 1'b0;
      bus.wr <= 1'b0;
    end else begin
      cs_q   <= cs1_n;
      we_q   <= we0_n;
      act_q  <= act;
      bus.wr <= start;
    end
  end

  // Address and data go out together with wr
  always_ff @(posedge CPU_CKIO) begin
    if (start) begin
      bus.sel   <= addr[16:15];
      bus.waddr <= addr[14:1];
      bus.wdata <= data;
    end
  end

endmodule

`default_nettype wire

// File: cpu_bus_if.sv
// Decoded write side of the CPU bus, single cycle wr strobe
// sel, waddr and wdata are only meaningful while wr is high
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;

  logic                  wr;
  logic [1:0]            sel;
  logic [13:0]           waddr;
  fpga_pkg::bus_word_u   wdata;

  modport master (
    output wr,
    output sel,
    output waddr,
    output wdata
  );

  modport slave (
    input wr,
    input sel,
    input waddr,
    input wdata
  );

endinterface

`default_nettype wire

// File: fpga_pkg.sv
// Types for the CPU bus data word
// One written word is read as a duty/phase pair or as two mod samples
`default_nettype none

package fpga_pkg;

  // Normal bank word
  typedef struct packed {
    logic [7:0] duty;
    logic [7:0] phase;
  } duty_phase_t;

  // Modulation bank word, two 8-bit samples
  typedef struct packed {
    logic [7:0] odd;   // Sample at index 2n+1
    logic [7:0] even;  // Sample at index 2n
  } mod_pair_t;

  typedef union packed {
    duty_phase_t dp;
    mod_pair_t   pair;
  } bus_word_u;

endpackage

`default_nettype wire

// File: fpga_consts.svh
// Bank select codes, controller addresses and sizes for the CPU bus
// Bank code 3 (STM) is reserved and has no implementation
// Controller addresses not listed here are accepted and ignored
`ifndef FPGA_CONSTS_SVH
`define FPGA_CONSTS_SVH

////////////////////
// Bank select, addr[16:15]
`define BRAM_SELECT_CONTROLLER 2'd0
`define BRAM_SELECT_MOD        2'd1
`define BRAM_SELECT_NORMAL     2'd2

////////////////////
// Controller word addresses, addr[14:1]
`define ADDR_CTL_FLAG          14'h0000
`define ADDR_MOD_MEM_PAGE      14'h0020
`define ADDR_MOD_CYCLE         14'h0021
`define ADDR_MOD_FREQ_DIV_0    14'h0022
`define ADDR_MOD_FREQ_DIV_1    14'h0023

// Control word bits
`define CTL_FLAG_FORCE_FAN_BIT 4
`define CTL_FLAG_SYNC_BIT      8

////////////////////
// Sizes
`define NUM_TRANS              249
`define MOD_PAGE_WORDS         16384

`endif
